// ==== Makefile ====
BUILD := obj_dir
LOG   := sim.log

sim:
	verilator --binary --assert --timing -Mdir $(BUILD) --top-module tb_efpga_subsystem -f src.f
	./$(BUILD)/Vtb_efpga_subsystem | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

.PHONY: sim clean

// ==== src.f ====
verilog/efpga_pkg.sv
verilog/lint_if.sv
verilog/control_sync.sv
verilog/lint_cfg_port.sv
verilog/lint_cdc_slice.sv
verilog/event_bridge.sv
verilog/efpga_subsystem.sv
tb/tb_efpga_subsystem.sv

// ==== tb/efpga_testdata.txt ====
# C word | G word cycles | W addr be data | R addr expected_data | A apb_enable
# E event_enable mask expected_pulse_mask (all hex except the G cycle count)
C 1234abcd
C 00c0ffee
G deadbeef 2
G 00000000 1
C 5a5a0f0f
R 00010 a5c00010
W 00010 f 11223344
R 00010 11223344
W 00014 3 0000beef
R 00014 a5c0beef
W 00018 c cafe0000
R 00018 cafe0018
W 00010 6 00aa5500
R 00010 11aa5544
W 3fffc 9 77000088
R 3fffc 77c3ff88
A 0
W 00020 f 99999999
R 00010 00000000
A 1
R 00020 a5c00020
E 1 0001 0001
E 1 8421 8421
E 0 00ff 0000
E 1 ffff ffff
G 12345678 2

// ==== tb/tb_efpga_subsystem.sv ====
// testbench for the eFPGA subsystem boundary
// replays tb/efpga_testdata.txt against a fabric register model
`timescale 1ns/10ps

module tb_efpga_subsystem;
   import efpga_pkg::*;

   localparam int LINT_TIMEOUT = 200;  // asic cycles
   localparam int CTRL_TIMEOUT = 40;   // fpga cycles
   localparam int EVT_TIMEOUT  = 40;   // asic cycles

   logic                      asic_clk_i;
   logic                      fpga_clk_i;
   logic                      rst_n;
   logic [DATA_W-1:0]         control_in_i;
   logic [DATA_W-1:0]         efpga_control_o;
   logic                      enable_apb_i;
   logic                      enable_events_i;
   logic                      lint_req_i;
   logic [LINT_ADDR_W-1:0]    lint_add_i;
   logic                      lint_wen_i;
   logic [DATA_W-1:0]         lint_wdata_i;
   logic [BE_W-1:0]           lint_be_i;
   logic                      lint_gnt_o;
   logic                      lint_rvalid_o;
   logic [DATA_W-1:0]         lint_rdata_o;
   logic                      fab_req_o;
   logic [LINT_ADDR_W-1:0]    fab_add_o;
   logic                      fab_wen_o;
   logic [DATA_W-1:0]         fab_wdata_o;
   logic [BE_W-1:0]           fab_be_o;
   logic                      fab_gnt_i;
   logic                      fab_valid_i;
   logic [DATA_W-1:0]         fab_rdata_i;
   logic [N_EFPGA_EVENTS-1:0] fab_event_i;
   logic [N_EFPGA_EVENTS-1:0] efpga_event_o;

   int errors;
   int checks;
   int fab_grants;
   int expected_grants;
   int pulse_cnt  [N_EFPGA_EVENTS];  // running pulse count per event bit
   int pulse_base [N_EFPGA_EVENTS];
   logic [DATA_W-1:0] fab_mem [logic [LINT_ADDR_W-1:0]];

   efpga_subsystem efpga_subsystem_inst (.*);

   initial begin
      asic_clk_i = 1'b0;
      forever #20 asic_clk_i = ~asic_clk_i;
   end

   initial begin
      fpga_clk_i = 1'b0;
      forever #28 fpga_clk_i = ~fpga_clk_i;
   end

   // unwritten fabric registers read back a word built from their address
   function automatic logic [DATA_W-1:0] fill_word(input logic [LINT_ADDR_W-1:0] addr);
      return {12'ha5c, addr};
   endfunction

   function automatic logic [N_EFPGA_EVENTS-1:0] pulses_since_base();
      logic [N_EFPGA_EVENTS-1:0] seen;
      seen = '0;
      for (int i = 0; i < N_EFPGA_EVENTS; i++) begin
         seen[i] = (pulse_cnt[i] != pulse_base[i]);
      end
      return seen;
   endfunction

   task automatic check_equal(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_condition(input logic ok, input string what);
      checks++;
      assert (ok) else begin
         errors++;
         $display("%s", what);
      end
   endtask

   always @(negedge asic_clk_i) begin
      for (int i = 0; i < N_EFPGA_EVENTS; i++) begin
         if (efpga_event_o[i]) pulse_cnt[i] = pulse_cnt[i] + 1;
      end
   end

   // fabric register model with 0..3 cycle grant and valid delays
   initial begin : fabric_model
      int                gnt_wait;
      int                vld_wait;
      logic [DATA_W-1:0] word;
      fab_gnt_i   = 1'b0;
      fab_valid_i = 1'b0;
      fab_rdata_i = '0;
      fab_grants  = 0;
      void'($urandom(32'h7c7e));
      forever begin
         @(negedge fpga_clk_i);
         if (fab_req_o) begin
            gnt_wait = $urandom_range(3, 0);
            vld_wait = $urandom_range(3, 0);
            repeat (gnt_wait) @(negedge fpga_clk_i);
            word = fab_mem.exists(fab_add_o) ? fab_mem[fab_add_o] : fill_word(fab_add_o);
            if (!fab_wen_o) begin
               for (int b = 0; b < BE_W; b++) begin
                  if (fab_be_o[b]) word[8*b +: 8] = fab_wdata_o[8*b +: 8];
               end
               fab_mem[fab_add_o] = word;
            end
            fab_gnt_i  = 1'b1;
            fab_grants = fab_grants + 1;
            if (vld_wait == 0) begin
               fab_valid_i = 1'b1;
               fab_rdata_i = word;
            end
            @(negedge fpga_clk_i);
            fab_gnt_i   = 1'b0;
            fab_valid_i = 1'b0;
            if (vld_wait != 0) begin
               repeat (vld_wait - 1) @(negedge fpga_clk_i);
               fab_valid_i = 1'b1;
               fab_rdata_i = word;
               @(negedge fpga_clk_i);
               fab_valid_i = 1'b0;
            end
         end
      end
   end

   task automatic hold_control(input logic [DATA_W-1:0] word);
      int waited;
      waited = 0;
      @(negedge asic_clk_i);
      control_in_i = word;
      repeat (10) @(negedge asic_clk_i);
      while (efpga_control_o != word && waited < CTRL_TIMEOUT) begin
         @(negedge fpga_clk_i);
         waited++;
      end
      check_equal($sformatf("control %h", word), word, efpga_control_o);
   endtask

   task automatic glitch_control(input logic [DATA_W-1:0] word, input int cycles);
      logic [DATA_W-1:0] prev;
      prev = control_in_i;
      @(negedge asic_clk_i);
      control_in_i = word;
      repeat (cycles) @(negedge asic_clk_i);
      control_in_i = prev;
      repeat (20) begin
         @(negedge fpga_clk_i);
         check_equal($sformatf("glitch %h", word), prev, efpga_control_o);
      end
   endtask

   task automatic lint_access(input string name, input logic wen,
                              input logic [LINT_ADDR_W-1:0] addr, input logic [BE_W-1:0] be,
                              input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp);
      int   waited;
      logic bypass;
      waited = 0;
      @(negedge asic_clk_i);
      bypass       = !enable_apb_i;
      lint_req_i   = 1'b1;
      lint_add_i   = addr;
      lint_wen_i   = wen;
      lint_wdata_i = wdata;
      lint_be_i    = be;
      do begin
         @(negedge asic_clk_i);
         waited++;
      end while (!lint_gnt_o && waited < LINT_TIMEOUT);
      check_condition(lint_gnt_o, $sformatf("timeout waiting for lint grant on %s", name));
      check_equal($sformatf("%s rvalid", name), 32'd1, 32'(lint_rvalid_o));
      if (wen) check_equal(name, exp, lint_rdata_o);
      if (bypass) begin
         check_condition(waited == 1, $sformatf("%s granted late with bridge off", name));
      end else begin
         check_condition(waited >= GNT_DLY, $sformatf("%s granted too early", name));
         expected_grants++;
      end
      @(negedge asic_clk_i);
      lint_req_i = 1'b0;
      @(negedge asic_clk_i);
      if (bypass) begin
         repeat (8) begin  // long enough for a launch to cross
            @(negedge fpga_clk_i);
            check_condition(!fab_req_o,
                            $sformatf("%s reached the fabric with bridge off", name));
         end
      end
      check_equal($sformatf("%s fabric grants", name), expected_grants, fab_grants);
   endtask

   task automatic event_round(input logic en, input logic [N_EFPGA_EVENTS-1:0] mask,
                              input logic [N_EFPGA_EVENTS-1:0] exp_mask);
      int waited;
      waited = 0;
      @(negedge fpga_clk_i);
      enable_events_i = en;
      pulse_base      = pulse_cnt;
      repeat (2) @(negedge fpga_clk_i);
      fab_event_i = mask;
      repeat (2) @(negedge fpga_clk_i);
      fab_event_i = '0;
      while (pulses_since_base() != exp_mask && waited < EVT_TIMEOUT) begin
         @(posedge asic_clk_i);
         waited++;
      end
      repeat (20) @(posedge asic_clk_i);  // late or extra pulses
      check_equal($sformatf("events %h", mask), 32'(exp_mask), 32'(pulses_since_base()));
      for (int i = 0; i < N_EFPGA_EVENTS; i++) begin
         check_equal($sformatf("event %0d pulse count", i), 32'(exp_mask[i]),
                     pulse_cnt[i] - pulse_base[i]);
      end
   endtask

   initial begin : player
      int                        fd;
      int                        c;
      int                        cycles;
      logic [7:0]                cmd;
      logic [DATA_W-1:0]         word;
      logic [LINT_ADDR_W-1:0]    addr;
      logic [BE_W-1:0]           be;
      logic [N_EFPGA_EVENTS-1:0] mask;
      logic [N_EFPGA_EVENTS-1:0] exp_mask;
      logic                      en;
      errors          = 0;
      checks          = 0;
      expected_grants = 0;
      rst_n           = 1'b0;
      control_in_i    = '0;
      enable_apb_i    = 1'b1;
      enable_events_i = 1'b0;
      lint_req_i      = 1'b0;
      lint_add_i      = '0;
      lint_wen_i      = 1'b1;
      lint_wdata_i    = '0;
      lint_be_i       = '0;
      fab_event_i     = '0;
      repeat (4) @(negedge asic_clk_i);
      rst_n = 1'b1;
      @(negedge asic_clk_i);
      check_equal("reset fab_req_o", '0, 32'(fab_req_o));
      check_equal("reset lint_gnt_o", '0, 32'(lint_gnt_o));
      check_equal("reset lint_rvalid_o", '0, 32'(lint_rvalid_o));
      check_equal("reset efpga_event_o", '0, 32'(efpga_event_o));
      check_equal("reset efpga_control_o", '0, efpga_control_o);
      fd = $fopen("tb/efpga_testdata.txt", "r");
      check_condition(fd != 0, "cannot open tb/efpga_testdata.txt");
      if (fd != 0) begin
         while ($fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
               "#": begin
                  c = 0;
                  while (c != 10 && c != -1) begin
                     c = $fgetc(fd);
                  end
               end
               "C": begin
                  void'($fscanf(fd, "%h", word));
                  hold_control(word);
               end
               "G": begin
                  void'($fscanf(fd, "%h %d", word, cycles));
                  glitch_control(word, cycles);
               end
               "W": begin
                  void'($fscanf(fd, "%h %h %h", addr, be, word));
                  lint_access($sformatf("write %h", addr), 1'b0, addr, be, word, '0);
               end
               "R": begin
                  void'($fscanf(fd, "%h %h", addr, word));
                  lint_access($sformatf("read %h", addr), 1'b1, addr, '0, '0, word);
               end
               "A": begin
                  void'($fscanf(fd, "%h", en));
                  @(negedge asic_clk_i);
                  enable_apb_i = en;
               end
               "E": begin
                  void'($fscanf(fd, "%h %h %h", en, mask, exp_mask));
                  event_round(en, mask, exp_mask);
               end
               default: check_condition(1'b0, $sformatf("unknown command %c in test data", cmd));
            endcase
         end
         $fclose(fd);
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog/control_sync.sv ====
// control word crossing
// filters out words not held for three asic samples, then loads the fabric copy
`timescale 1ns/10ps

module control_sync (
   input  logic                         asic_clk_i,
   input  logic                         fpga_clk_i,
   input  logic                         rst_n,
   input  logic [efpga_pkg::DATA_W-1:0] control_in_i,
   output logic [efpga_pkg::DATA_W-1:0] efpga_control_o
);
   import efpga_pkg::*;

   logic [DATA_W-1:0]      ctrl_d1_q;
   logic [DATA_W-1:0]      ctrl_d2_q;
   logic [DATA_W-1:0]      ctrl_hold_q;     // last accepted word
   logic                   stable_q;
   logic [SYNC_STAGES-1:0] stable_sync_q;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_d1_q <= '0;
         ctrl_d2_q <= '0;
         stable_q  <= 1'b0;
      end else begin
         ctrl_d1_q <= control_in_i;
         ctrl_d2_q <= ctrl_d1_q;
         stable_q  <= (ctrl_d1_q == control_in_i) && (ctrl_d2_q == control_in_i);
      end
   end

   // only moves once the word has passed the filter
   always_ff @(posedge asic_clk_i) begin
      if (stable_q) begin
         ctrl_hold_q <= ctrl_d2_q;
      end
   end

   always_ff @(posedge fpga_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         stable_sync_q   <= '0;
         efpga_control_o <= '0;
      end else begin
         stable_sync_q <= {stable_sync_q[SYNC_STAGES-2:0], stable_q};
         if (stable_sync_q[SYNC_STAGES-1]) begin
            efpga_control_o <= ctrl_hold_q;
         end
      end
   end

endmodule

// ==== verilog/efpga_pkg.sv ====
// eFPGA boundary constants
// widths of the register-access path and timing of the clock-crossing logic

package efpga_pkg;

   // register-access (lint) path into the fabric
   localparam int LINT_ADDR_W = 20;  // fabric register address
   localparam int DATA_W      = 32;  // lint data, also the control word
   localparam int BE_W        = 4;   // one enable per byte

   // fabric event lines into the asic
   localparam int N_EFPGA_EVENTS = 16;

   // a control word is only forwarded after this many
   // matching asic samples in a row, so short glitches
   // on control_in_i never reach the fabric
   localparam int CTRL_STABLE_CYCLES = 3;

   // asic cycles a lint request is held before the grant
   // is allowed back, hides a stale done from the last access
   localparam int GNT_DLY = 4;

   // flops in every two-clock synchronizer
   localparam int SYNC_STAGES = 2;

endpackage

// ==== verilog/efpga_subsystem.sv ====
// eFPGA subsystem boundary
// control word crossing, lint bridge into the fabric and fabric event return
`timescale 1ns/10ps

module efpga_subsystem (
   input  logic                                 asic_clk_i,
   input  logic                                 fpga_clk_i,
   input  logic                                 rst_n,

   input  logic [efpga_pkg::DATA_W-1:0]         control_in_i,
   output logic [efpga_pkg::DATA_W-1:0]         efpga_control_o,  // fabric clock

   input  logic                                 enable_apb_i,
   input  logic                                 enable_events_i,

   input  logic                                 lint_req_i,
   input  logic [efpga_pkg::LINT_ADDR_W-1:0]    lint_add_i,
   input  logic                                 lint_wen_i,
   input  logic [efpga_pkg::DATA_W-1:0]         lint_wdata_i,
   input  logic [efpga_pkg::BE_W-1:0]           lint_be_i,
   output logic                                 lint_gnt_o,
   output logic                                 lint_rvalid_o,
   output logic [efpga_pkg::DATA_W-1:0]         lint_rdata_o,

   output logic                                 fab_req_o,
   output logic [efpga_pkg::LINT_ADDR_W-1:0]    fab_add_o,
   output logic                                 fab_wen_o,
   output logic [efpga_pkg::DATA_W-1:0]         fab_wdata_o,
   output logic [efpga_pkg::BE_W-1:0]           fab_be_o,
   input  logic                                 fab_gnt_i,
   input  logic                                 fab_valid_i,
   input  logic [efpga_pkg::DATA_W-1:0]         fab_rdata_i,

   input  logic [efpga_pkg::N_EFPGA_EVENTS-1:0] fab_event_i,
   output logic [efpga_pkg::N_EFPGA_EVENTS-1:0] efpga_event_o
);

   lint_if lint_bus ();  // port to slice

   control_sync control_sync_inst (
      .asic_clk_i      (asic_clk_i),
      .fpga_clk_i      (fpga_clk_i),
      .rst_n           (rst_n),
      .control_in_i    (control_in_i),
      .efpga_control_o (efpga_control_o)
   );

   lint_cfg_port lint_cfg_port_inst (
      .asic_clk_i    (asic_clk_i),
      .rst_n         (rst_n),
      .enable_apb_i  (enable_apb_i),
      .lint_req_i    (lint_req_i),
      .lint_add_i    (lint_add_i),
      .lint_wen_i    (lint_wen_i),
      .lint_wdata_i  (lint_wdata_i),
      .lint_be_i     (lint_be_i),
      .lint_gnt_o    (lint_gnt_o),
      .lint_rvalid_o (lint_rvalid_o),
      .lint_rdata_o  (lint_rdata_o),
      .cdc           (lint_bus.master)
   );

   lint_cdc_slice lint_cdc_slice_inst (
      .asic_clk_i  (asic_clk_i),
      .fpga_clk_i  (fpga_clk_i),
      .rst_n       (rst_n),
      .cdc         (lint_bus.slave),
      .fab_req_o   (fab_req_o),
      .fab_add_o   (fab_add_o),
      .fab_wen_o   (fab_wen_o),
      .fab_wdata_o (fab_wdata_o),
      .fab_be_o    (fab_be_o),
      .fab_gnt_i   (fab_gnt_i),
      .fab_valid_i (fab_valid_i),
      .fab_rdata_i (fab_rdata_i)
   );

   event_bridge event_bridge_inst (
      .asic_clk_i      (asic_clk_i),
      .fpga_clk_i      (fpga_clk_i),
      .rst_n           (rst_n),
      .enable_events_i (enable_events_i),
      .fab_event_i     (fab_event_i),
      .efpga_event_o   (efpga_event_o)
   );

endmodule

// ==== verilog/event_bridge.sv ====
// fabric event propagation
// gated rising edges become one asic-cycle pulses over a level handshake
`timescale 1ns/10ps

module event_bridge (
   input  logic                                 asic_clk_i,
   input  logic                                 fpga_clk_i,
   input  logic                                 rst_n,
   input  logic                                 enable_events_i,
   input  logic [efpga_pkg::N_EFPGA_EVENTS-1:0] fab_event_i,
   output logic [efpga_pkg::N_EFPGA_EVENTS-1:0] efpga_event_o
);
   import efpga_pkg::*;

   for (genvar i = 0; i < N_EFPGA_EVENTS; i++) begin : gen_event
      logic                   evt_gated;
      logic                   evt_prev_q;
      logic                   pend_q;       // held until the asic acknowledges
      logic [SYNC_STAGES-1:0] ack_sync_q;
      logic [SYNC_STAGES-1:0] lvl_sync_q;
      logic                   lvl_q;

      assign evt_gated = fab_event_i[i] & enable_events_i;

      always_ff @(posedge fpga_clk_i or negedge rst_n) begin
         if (!rst_n) begin
            evt_prev_q <= 1'b0;
            ack_sync_q <= '0;
            pend_q     <= 1'b0;
         end else begin
            evt_prev_q <= evt_gated;
            ack_sync_q <= {ack_sync_q[SYNC_STAGES-2:0], lvl_q};
            if (pend_q && ack_sync_q[SYNC_STAGES-1]) begin
               pend_q <= 1'b0;
            end else if (evt_gated && !evt_prev_q && !ack_sync_q[SYNC_STAGES-1]) begin
               pend_q <= 1'b1;  // edges while pending just merge
            end
         end
      end

      always_ff @(posedge asic_clk_i or negedge rst_n) begin
         if (!rst_n) begin
            lvl_sync_q <= '0;
            lvl_q      <= 1'b0;
         end else begin
            lvl_sync_q <= {lvl_sync_q[SYNC_STAGES-2:0], pend_q};
            lvl_q      <= lvl_sync_q[SYNC_STAGES-1];  // also the ack
         end
      end

      assign efpga_event_o[i] = lvl_sync_q[SYNC_STAGES-1] & ~lvl_q;
   end

   a_single_pulse : assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      (efpga_event_o & $past(efpga_event_o)) == '0);

endmodule

// ==== verilog/lint_cdc_slice.sv ====
// dual-clock lint slice
// one request in flight, carried by toggles between the asic and fabric clocks
`timescale 1ns/10ps

module lint_cdc_slice (
   input  logic                              asic_clk_i,
   input  logic                              fpga_clk_i,
   input  logic                              rst_n,
   lint_if.slave                             cdc,
   output logic                              fab_req_o,
   output logic [efpga_pkg::LINT_ADDR_W-1:0] fab_add_o,
   output logic                              fab_wen_o,
   output logic [efpga_pkg::DATA_W-1:0]      fab_wdata_o,
   output logic [efpga_pkg::BE_W-1:0]        fab_be_o,
   input  logic                              fab_gnt_i,
   input  logic                              fab_valid_i,
   input  logic [efpga_pkg::DATA_W-1:0]      fab_rdata_i
);
   import efpga_pkg::*;

   // asic side
   logic                   req_tgl_q;
   logic [SYNC_STAGES-1:0] rsp_sync_q;
   logic                   rsp_seen_q;
   logic                   done_q;
   logic [LINT_ADDR_W-1:0] add_q;
   logic                   wen_q;
   logic [DATA_W-1:0]      wdata_q;
   logic [BE_W-1:0]        be_q;

   // fabric side
   logic [SYNC_STAGES-1:0] req_sync_q;
   logic                   req_seen_q;
   logic                   fab_req_q;
   logic                   wait_valid_q;   // granted, response still due
   logic                   rsp_tgl_q;
   logic [DATA_W-1:0]      rdata_q;
   logic                   fab_done;

   always_ff @(posedge asic_clk_i) begin
      if (cdc.req) begin
         add_q   <= cdc.add;
         wen_q   <= cdc.wen;
         wdata_q <= cdc.wdata;
         be_q    <= cdc.be;
      end
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         req_tgl_q  <= 1'b0;
         rsp_sync_q <= '0;
         rsp_seen_q <= 1'b0;
         done_q     <= 1'b0;
      end else begin
         req_tgl_q  <= req_tgl_q ^ cdc.req;
         rsp_sync_q <= {rsp_sync_q[SYNC_STAGES-2:0], rsp_tgl_q};
         rsp_seen_q <= rsp_sync_q[SYNC_STAGES-1];
         if (cdc.req) begin
            done_q <= 1'b0;
         end else if (rsp_sync_q[SYNC_STAGES-1] != rsp_seen_q) begin
            done_q <= 1'b1;
         end
      end
   end

   assign cdc.gnt     = done_q;
   assign cdc.r_valid = done_q;
   assign cdc.r_rdata = rdata_q;  // settled before the toggle gets back

   // first valid at or after the grant closes the access
   assign fab_done = fab_valid_i & ((fab_req_q & fab_gnt_i) | wait_valid_q);

   always_ff @(posedge fpga_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         req_sync_q   <= '0;
         req_seen_q   <= 1'b0;
         fab_req_q    <= 1'b0;
         wait_valid_q <= 1'b0;
         rsp_tgl_q    <= 1'b0;
      end else begin
         req_sync_q <= {req_sync_q[SYNC_STAGES-2:0], req_tgl_q};
         req_seen_q <= req_sync_q[SYNC_STAGES-1];
         if (req_sync_q[SYNC_STAGES-1] != req_seen_q) begin
            fab_req_q <= 1'b1;
         end else if (fab_gnt_i) begin
            fab_req_q <= 1'b0;
         end
         if (fab_req_q && fab_gnt_i && !fab_valid_i) begin
            wait_valid_q <= 1'b1;
         end else if (fab_valid_i) begin
            wait_valid_q <= 1'b0;
         end
         if (fab_done) begin
            rsp_tgl_q <= ~rsp_tgl_q;
         end
      end
   end

   always_ff @(posedge fpga_clk_i) begin
      if (fab_done) begin
         rdata_q <= fab_rdata_i;
      end
   end

   assign fab_req_o   = fab_req_q;
   assign fab_add_o   = add_q;  // asic copy, quiet while the request crosses
   assign fab_wen_o   = wen_q;
   assign fab_wdata_o = wdata_q;
   assign fab_be_o    = be_q;

   a_fab_hold : assert property (@(posedge fpga_clk_i) disable iff (!rst_n)
      fab_req_o && !fab_gnt_i |=>
         fab_req_o && $stable({fab_wen_o, fab_add_o, fab_be_o, fab_wdata_o}));

endmodule

// ==== verilog/lint_cfg_port.sv ====
// asic-side lint port
// shapes the grant with a delay line and answers locally when the bridge is off
`timescale 1ns/10ps

module lint_cfg_port (
   input  logic                              asic_clk_i,
   input  logic                              rst_n,
   input  logic                              enable_apb_i,
   input  logic                              lint_req_i,
   input  logic [efpga_pkg::LINT_ADDR_W-1:0] lint_add_i,
   input  logic                              lint_wen_i,
   input  logic [efpga_pkg::DATA_W-1:0]      lint_wdata_i,
   input  logic [efpga_pkg::BE_W-1:0]        lint_be_i,
   output logic                              lint_gnt_o,
   output logic                              lint_rvalid_o,
   output logic [efpga_pkg::DATA_W-1:0]      lint_rdata_o,
   lint_if.master                            cdc
);
   import efpga_pkg::*;

   logic [GNT_DLY-1:0] gnt_dly_q;  // fills with ones while req is held

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         gnt_dly_q <= '0;
      end else if (!lint_req_i) begin
         gnt_dly_q <= '0;
      end else begin
         gnt_dly_q <= {gnt_dly_q[GNT_DLY-2:0], 1'b1};
      end
   end

   // launch once, on the first cycle of a request
   assign cdc.req   = enable_apb_i & lint_req_i & ~(gnt_dly_q[0] | gnt_dly_q[1]);
   assign cdc.add   = lint_add_i;
   assign cdc.wen   = lint_wen_i;
   assign cdc.wdata = lint_wdata_i;
   assign cdc.be    = lint_be_i;

   always_comb begin
      if (enable_apb_i) begin
         lint_gnt_o    = lint_req_i & gnt_dly_q[GNT_DLY-1] & cdc.gnt;
         lint_rvalid_o = cdc.r_valid;
         lint_rdata_o  = cdc.r_rdata;
      end else begin
         lint_gnt_o    = lint_req_i;  // bridge off, grant at once
         lint_rvalid_o = 1'b1;
         lint_rdata_o  = '0;
      end
   end

   // grant only with a live request, held GNT_DLY cycles when the bridge is on
   a_gnt_needs_req : assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      lint_gnt_o |-> lint_req_i && (!enable_apb_i || $past(lint_req_i, GNT_DLY)));

endmodule

// ==== verilog/lint_if.sv ====
// lint channel between the asic-side port and the clock-crossing slice
// request with payload one way, grant/valid/read data the other
`timescale 1ns/10ps

interface lint_if;
   import efpga_pkg::*;

   logic                   req;      // single-cycle launch
   logic [LINT_ADDR_W-1:0] add;
   logic                   wen;      // 1 = read
   logic [DATA_W-1:0]      wdata;
   logic [BE_W-1:0]        be;
   logic                   gnt;
   logic                   r_valid;
   logic [DATA_W-1:0]      r_rdata;

   modport master (
      output req, add, wen, wdata, be,
      input  gnt, r_valid, r_rdata
   );

   modport slave (
      input  req, add, wen, wdata, be,
      output gnt, r_valid, r_rdata
   );

endinterface
